// File: vlog.f
+incdir+sim
logic/omsp_trace_pkg.sv
logic/omsp_trace_capture.sv
logic/omsp_inst_decode.sv
logic/omsp_operand_mode.sv
logic/omsp_trace_top.sv
sim/omsp_trace_asserts.sv
sim/tb_omsp_trace.sv

// File: sim/omsp_trace_model.svh
// Reference model functions giving the expected trace fields of a captured instruction word
`ifndef OMSP_TRACE_MODEL_SVH
`define OMSP_TRACE_MODEL_SVH

////////////////////////////////////////
// Classification
////////////////////////////////////////

// Interrupt flag first, then the three top bits
function automatic logic [1:0] word_format(input logic [15:0] w, input logic irq);
  if (irq) begin
    return FMT_IRQ;
  end
  case (w[15:13])
    3'b000:  return FMT_SIG_OP;
    3'b001:  return FMT_JUMP;
    default: return FMT_TWO_OP;
  endcase
endfunction

// Exact NOP and SBREAK words win in every format
function automatic logic [5:0] mnemonic_code(input logic [15:0] w, input logic irq,
                                             input logic [3:0] num);
  logic [1:0] f;
  f = word_format(w, irq);
  if (w == 16'h4303) begin
    return 6'd28;
  end
  if (w == 16'h4343) begin
    return 6'd29;
  end
  case (f)
    FMT_IRQ:    return 6'd32 + {2'b00, num};
    // Prefix 000100 and opc 0..6 only
    FMT_SIG_OP: return ((w[15:10] == 6'b000100) && (w[9:7] != 3'b111)) ?
                       {3'b000, w[9:7]} : 6'd7;
    FMT_JUMP:   return 6'd8 + {3'b000, w[12:10]};
    // MOV is opc 4 and mnemonic 16
    default:    return {2'b00, w[15:12]} + 6'd12;
  endcase
endfunction

// Byte flag lives in bit 6 of both operand formats
function automatic logic byte_flag(input logic [15:0] w, input logic irq);
  logic [1:0] f;
  f = word_format(w, irq);
  return ((f == FMT_SIG_OP) || (f == FMT_TWO_OP)) ? w[6] : 1'b0;
endfunction

function automatic logic [3:0] src_register(input logic [15:0] w, input logic irq);
  logic [1:0] f;
  f = word_format(w, irq);
  if (f == FMT_SIG_OP) begin
    return w[3:0];
  end
  return (f == FMT_TWO_OP) ? w[11:8] : 4'd0;
endfunction

function automatic logic [3:0] dst_register(input logic [15:0] w, input logic irq);
  return (word_format(w, irq) == FMT_TWO_OP) ? w[3:0] : 4'd0;
endfunction

////////////////////////////////////////
// Addressing modes
////////////////////////////////////////

// R3 constants, R2 as SR, R0 as PC, the rest general
function automatic logic [3:0] src_addr_mode(input logic [15:0] w, input logic irq);
  logic [1:0] f;
  logic [3:0] r;
  logic [1:0] as_bits;
  f       = word_format(w, irq);
  r       = src_register(w, irq);
  as_bits = w[5:4];
  if ((f == FMT_IRQ) || (f == FMT_JUMP)) begin
    return AM_NONE;
  end
  if (as_bits == 2'd0) begin
    return (r == 4'd3) ? AM_CONST : AM_REG;
  end
  case (r)
    4'd3:    return AM_CONST;
    4'd2:    return (as_bits == 2'd1) ? AM_ABSOLUTE : AM_CONST;
    4'd0:    return (as_bits == 2'd1) ? AM_SYMBOLIC :
                    (as_bits == 2'd2) ? AM_INDIRECT : AM_IMMEDIATE;
    default: return (as_bits == 2'd1) ? AM_INDEXED :
                    (as_bits == 2'd2) ? AM_INDIRECT : AM_AUTOINC;
  endcase
endfunction

// Nonzero only in constant mode
function automatic logic [15:0] const_value(input logic [15:0] w, input logic irq);
  logic [15:0] r3_table [4];
  r3_table = '{16'h0000, 16'h0001, 16'h0002, 16'hFFFF};
  if (src_addr_mode(w, irq) != AM_CONST) begin
    return 16'h0000;
  end
  if (src_register(w, irq) == 4'd3) begin
    return r3_table[w[5:4]];
  end
  return (w[5:4] == 2'd2) ? 16'h0004 : 16'h0008;
endfunction

function automatic logic [3:0] dst_addr_mode(input logic [15:0] w, input logic irq);
  if (word_format(w, irq) != FMT_TWO_OP) begin
    return AM_NONE;
  end
  if (!w[7]) begin
    return AM_REG;
  end
  case (w[3:0])
    4'd2:    return AM_ABSOLUTE;
    4'd0:    return AM_SYMBOLIC;
    default: return AM_INDEXED;
  endcase
endfunction

`endif

// File: sim/tb_omsp_trace.sv
// Testbench for the instruction trace unit with seeded random stimulus and a reference model
module tb_omsp_trace import omsp_trace_pkg::*; ();

  localparam int unsigned N_CYCLES       = 2000;
  // Run length plus margin
  localparam int unsigned TIMEOUT_CYCLES = N_CYCLES + 100;

  logic              mclk;
  logic              puc_rst;
  logic              i_decode;
  logic [DATA_W-1:0] i_ir;
  logic [DATA_W-1:0] i_pc;
  logic              i_irq_detect;
  logic [IRQ_W-1:0]  i_irq_num;
  logic [CNT_W-1:0]  o_inst_number;
  logic [CNT_W-1:0]  o_inst_cycle;
  logic [DATA_W-1:0] o_inst_pc;
  logic [FMT_W-1:0]  o_fmt;
  logic [MNEM_W-1:0] o_mnem;
  logic              o_byte;
  logic [REG_W-1:0]  o_src_reg;
  logic [REG_W-1:0]  o_dst_reg;
  logic [AM_W-1:0]   o_src_mode;
  logic [DATA_W-1:0] o_src_const;
  logic [AM_W-1:0]   o_dst_mode;

  // Model state at the last rising edge
  logic [15:0] m_ir;
  logic [15:0] m_pc;
  logic        m_irq;
  logic [3:0]  m_irq_num;
  logic [31:0] m_number;
  logic [31:0] m_cycle;

  int unsigned cycle_cnt = 0;

  `include "omsp_trace_model.svh"

  omsp_trace_top dut (
    .mclk          (mclk),
    .puc_rst       (puc_rst),
    .i_decode      (i_decode),
    .i_ir          (i_ir),
    .i_pc          (i_pc),
    .i_irq_detect  (i_irq_detect),
    .i_irq_num     (i_irq_num),
    .o_inst_number (o_inst_number),
    .o_inst_cycle  (o_inst_cycle),
    .o_inst_pc     (o_inst_pc),
    .o_fmt         (o_fmt),
    .o_mnem        (o_mnem),
    .o_byte        (o_byte),
    .o_src_reg     (o_src_reg),
    .o_dst_reg     (o_dst_reg),
    .o_src_mode    (o_src_mode),
    .o_src_const   (o_src_const),
    .o_dst_mode    (o_dst_mode)
  );

  always #20 mclk = ~mclk;

  // Cycles since reset release
  always @(posedge mclk) begin
    if (!puc_rst) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Timeout: run still going %0d cycles after reset", TIMEOUT_CYCLES);
        $display("Verification failed");
        $fatal(1, "simulation timed out");
      end
    end
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("ERR t=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp_val, act_val);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // All outputs against the model
  task automatic compare_outputs();
    // Bound counter assertions on the capture stage
    if (dut.u_capture.u_asserts.fail_count != 0) begin
      $display("A capture stage assertion failed before t=%0t", $time);
      $display("Verification failed");
      $fatal(1, "assertion failure");
    end
    check_value("o_inst_number", m_number, o_inst_number);
    check_value("o_inst_cycle", m_cycle, o_inst_cycle);
    check_value("o_inst_pc", 32'(m_pc), 32'(o_inst_pc));
    check_value("o_fmt", 32'(word_format(m_ir, m_irq)), 32'(o_fmt));
    check_value("o_mnem", 32'(mnemonic_code(m_ir, m_irq, m_irq_num)), 32'(o_mnem));
    check_value("o_byte", 32'(byte_flag(m_ir, m_irq)), 32'(o_byte));
    check_value("o_src_reg", 32'(src_register(m_ir, m_irq)), 32'(o_src_reg));
    check_value("o_dst_reg", 32'(dst_register(m_ir, m_irq)), 32'(o_dst_reg));
    check_value("o_src_mode", 32'(src_addr_mode(m_ir, m_irq)), 32'(o_src_mode));
    check_value("o_src_const", 32'(const_value(m_ir, m_irq)), 32'(o_src_const));
    check_value("o_dst_mode", 32'(dst_addr_mode(m_ir, m_irq)), 32'(o_dst_mode));
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // R0, R2 and R3 have their own tables
  function automatic logic [3:0] pick_reg();
    case ($urandom_range(3, 0))
      0:       return 4'd0;
      1:       return 4'd2;
      2:       return 4'd3;
      default: return 4'($urandom);
    endcase
  endfunction

  // Mix of formats plus the two exact words
  function automatic logic [15:0] random_word();
    logic [3:0] opc;
    opc = 4'd4 + 4'($urandom_range(11, 0));
    case ($urandom_range(9, 0))
      0, 1, 2: begin
        // Now and then a bad prefix
        if ($urandom_range(3, 0) == 0) begin
          return {3'b000, 13'($urandom)};
        end
        return {SIG_PREFIX, 6'($urandom), pick_reg()};
      end
      3, 4:    return {JUMP_PREFIX, 13'($urandom)};
      5, 6, 7: return {opc, pick_reg(), 8'($urandom)};
      8:       return OP_NOP;
      default: return OP_SBREAK;
    endcase
  endfunction

  task automatic drive_random();
    i_decode     = ($urandom_range(2, 0) == 0);
    i_ir         = random_word();
    i_pc         = 16'($urandom);
    i_irq_detect = ($urandom_range(7, 0) == 0);
    i_irq_num    = 4'($urandom);
  endtask

  // Next rising edge as the model sees it
  task automatic step_model();
    if (i_decode) begin
      m_ir      = i_ir;
      m_pc      = i_pc;
      m_irq     = i_irq_detect;
      m_irq_num = i_irq_num;
      m_number  = m_number + 1;
      m_cycle   = 0;
    end else begin
      m_cycle = m_cycle + 1;
    end
  endtask

  initial begin
    void'($urandom(32'h27ad));
    mclk         = 1'b0;
    puc_rst      = 1'b1;
    i_decode     = 1'b0;
    i_ir         = '0;
    i_pc         = '0;
    i_irq_detect = 1'b0;
    i_irq_num    = '0;
    // Reset state is the RESET vector
    m_ir      = '0;
    m_pc      = '0;
    m_irq     = 1'b1;
    m_irq_num = 4'hF;
    m_number  = '0;
    m_cycle   = '0;
    repeat (10) @(negedge mclk);
    puc_rst = 1'b0;
    check_value("o_fmt", 32'(FMT_IRQ), 32'(o_fmt));
    check_value("o_mnem", 32'(MN_IRQ_BASE + 6'd15), 32'(o_mnem));
    check_value("o_src_mode", 32'(AM_NONE), 32'(o_src_mode));
    check_value("o_dst_mode", 32'(AM_NONE), 32'(o_dst_mode));
    for (int i = 0; i < N_CYCLES; i++) begin
      compare_outputs();
      drive_random();
      step_model();
      @(negedge mclk);
    end
    compare_outputs();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: sim/omsp_trace_asserts.sv
// Concurrent checks on the capture stage counters around decode strobes and reset
module omsp_trace_asserts import omsp_trace_pkg::*; (
  input logic             mclk,
  input logic             puc_rst,
  input logic             i_decode,
  input logic [CNT_W-1:0] i_inst_number,
  input logic [CNT_W-1:0] i_inst_cycle
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // Cycle count restarts on a strobe
  cycle_clear_on_decode: assert property (@(posedge mclk) disable iff (puc_rst)
    i_decode |=> (i_inst_cycle == '0))
    else begin
      fail_count++;
      $error("cycle count not cleared after decode edge");
    end

  // Exactly one instruction per strobe
  number_step_on_decode: assert property (@(posedge mclk) disable iff (puc_rst)
    i_decode |=> (i_inst_number == $past(i_inst_number) + 32'd1))
    else begin
      fail_count++;
      $error("instruction count did not step by one");
    end

  // Both counts pinned at zero in reset
  counts_held_in_reset: assert property (@(posedge mclk)
    puc_rst |-> ((i_inst_number == '0) && (i_inst_cycle == '0)))
    else begin
      fail_count++;
      $error("counts moved during reset");
    end

endmodule

bind omsp_trace_capture omsp_trace_asserts u_asserts (
  .mclk          (mclk),
  .puc_rst       (puc_rst),
  .i_decode      (i_decode),
  .i_inst_number (o_inst_number),
  .i_inst_cycle  (o_inst_cycle)
);

// File: logic/omsp_trace_top.sv
// Instruction trace top level joining the capture stage, opcode classifier and operand resolver
module omsp_trace_top import omsp_trace_pkg::*; (
  input  logic              mclk,
  input  logic              puc_rst,
  // Core decode strobe and sampled state
  input  logic              i_decode,
  input  logic [DATA_W-1:0] i_ir,
  input  logic [DATA_W-1:0] i_pc,
  input  logic              i_irq_detect,
  input  logic [IRQ_W-1:0]  i_irq_num,
  // Counters and pc of the traced instruction
  output logic [CNT_W-1:0]  o_inst_number,
  output logic [CNT_W-1:0]  o_inst_cycle,
  output logic [DATA_W-1:0] o_inst_pc,
  // Decoded trace fields
  output logic [FMT_W-1:0]  o_fmt,
  output logic [MNEM_W-1:0] o_mnem,
  output logic              o_byte,
  output logic [REG_W-1:0]  o_src_reg,
  output logic [REG_W-1:0]  o_dst_reg,
  output logic [AM_W-1:0]   o_src_mode,
  output logic [DATA_W-1:0] o_src_const,
  output logic [AM_W-1:0]   o_dst_mode
);

  // Registered instruction state
  op_word_u         opcode;
  logic             irq;
  logic [IRQ_W-1:0] irq_num;

  ////////////////////////////////////////
  // Capture stage
  ////////////////////////////////////////

  omsp_trace_capture u_capture (
    .mclk          (mclk),
    .puc_rst       (puc_rst),
    .i_decode      (i_decode),
    .i_ir          (i_ir),
    .i_pc          (i_pc),
    .i_irq_detect  (i_irq_detect),
    .i_irq_num     (i_irq_num),
    .o_opcode      (opcode),
    .o_irq         (irq),
    .o_irq_num     (irq_num),
    .o_inst_pc     (o_inst_pc),
    .o_inst_number (o_inst_number),
    .o_inst_cycle  (o_inst_cycle)
  );

  // Format and register fields
  omsp_inst_decode u_decode (
    .i_opcode  (opcode),
    .i_irq     (irq),
    .i_irq_num (irq_num),
    .o_fmt     (o_fmt),
    .o_mnem    (o_mnem),
    .o_byte    (o_byte),
    .o_src_reg (o_src_reg),
    .o_dst_reg (o_dst_reg)
  );

  // Addressing modes, fed by the classifier
  omsp_operand_mode u_operand (
    .i_opcode    (opcode),
    .i_fmt       (o_fmt),
    .i_src_reg   (o_src_reg),
    .o_src_mode  (o_src_mode),
    .o_src_const (o_src_const),
    .o_dst_mode  (o_dst_mode)
  );

endmodule

// File: logic/omsp_operand_mode.sv
// Operand resolver giving source and destination addressing modes and constant values
module omsp_operand_mode import omsp_trace_pkg::*; (
  input  op_word_u          i_opcode,
  input  logic [FMT_W-1:0]  i_fmt,
  input  logic [REG_W-1:0]  i_src_reg,
  output logic [AM_W-1:0]   o_src_mode,
  output logic [DATA_W-1:0] o_src_const,
  output logic [AM_W-1:0]   o_dst_mode
);

  // As field, same bits in both operand formats
  logic [1:0] as_f;
  // Source operand present
  logic       has_src;

  assign as_f    = i_opcode.two_op.as;
  assign has_src = (i_fmt == FMT_SIG_OP) || (i_fmt == FMT_TWO_OP);

  ////////////////////////////////////////
  // Source addressing
  ////////////////////////////////////////

  always_comb begin
    o_src_mode  = AM_NONE;
    o_src_const = '0;
    if (has_src) begin
      case (i_src_reg)
        // R3 is the constant generator
        4'd3: begin
          o_src_mode = AM_CONST;
          case (as_f)
            2'd0:    o_src_const = 16'h0000;
            2'd1:    o_src_const = 16'h0001;
            2'd2:    o_src_const = 16'h0002;
            default: o_src_const = 16'hFFFF;
          endcase
        end
        // SR: register, &ADDR, then constants 4 and 8
        4'd2: begin
          case (as_f)
            2'd0: o_src_mode = AM_REG;
            2'd1: o_src_mode = AM_ABSOLUTE;
            2'd2: begin
              o_src_mode  = AM_CONST;
              o_src_const = 16'h0004;
            end
            default: begin
              o_src_mode  = AM_CONST;
              o_src_const = 16'h0008;
            end
          endcase
        end
        // PC relative forms
        4'd0: begin
          case (as_f)
            2'd0:    o_src_mode = AM_REG;
            2'd1:    o_src_mode = AM_SYMBOLIC;
            2'd2:    o_src_mode = AM_INDIRECT;
            default: o_src_mode = AM_IMMEDIATE;
          endcase
        end
        // General purpose registers
        default: begin
          case (as_f)
            2'd0:    o_src_mode = AM_REG;
            2'd1:    o_src_mode = AM_INDEXED;
            2'd2:    o_src_mode = AM_INDIRECT;
            default: o_src_mode = AM_AUTOINC;
          endcase
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Destination addressing
  ////////////////////////////////////////

  // Ad only exists in two-operand words
  always_comb begin
    if (i_fmt != FMT_TWO_OP) begin
      o_dst_mode = AM_NONE;
    end else if (!i_opcode.two_op.ad) begin
      o_dst_mode = AM_REG;
    end else if (i_opcode.two_op.dst == 4'd2) begin
      o_dst_mode = AM_ABSOLUTE;
    end else if (i_opcode.two_op.dst == 4'd0) begin
      o_dst_mode = AM_SYMBOLIC;
    end else begin
      o_dst_mode = AM_INDEXED;
    end
  end

endmodule

// File: logic/omsp_inst_decode.sv
// Opcode classifier giving format, mnemonic code, byte flag and register numbers
module omsp_inst_decode import omsp_trace_pkg::*; (
  input  op_word_u          i_opcode,
  input  logic              i_irq,
  input  logic [IRQ_W-1:0]  i_irq_num,
  output logic [FMT_W-1:0]  o_fmt,
  output logic [MNEM_W-1:0] o_mnem,
  output logic              o_byte,
  output logic [REG_W-1:0]  o_src_reg,
  output logic [REG_W-1:0]  o_dst_reg
);

  // Internal copy of the format
  logic [FMT_W-1:0]  fmt;
  // Mnemonic before the exact-word overrides
  logic [MNEM_W-1:0] mnem_base;
  // Single-operand word is a real instruction
  logic              sig_valid;

  ////////////////////////////////////////
  // Format
  ////////////////////////////////////////

  // Top three bits pick the format
  // 000 single-operand, 001 jump, rest two-operand
  always_comb begin
    if (i_irq) begin
      fmt = FMT_IRQ;
    end else if (i_opcode.jump.prefix == SIG_PREFIX[5:3]) begin
      fmt = FMT_SIG_OP;
    end else if (i_opcode.jump.prefix == JUMP_PREFIX) begin
      fmt = FMT_JUMP;
    end else begin
      fmt = FMT_TWO_OP;
    end
  end

  assign o_fmt = fmt;

  ////////////////////////////////////////
  // Mnemonic
  ////////////////////////////////////////

  // Full prefix must match and opc 7 is unused
  assign sig_valid = (i_opcode.sig_op.prefix == SIG_PREFIX) &&
                     (i_opcode.sig_op.opc != 3'd7);

  always_comb begin
    case (fmt)
      FMT_IRQ: begin
        // Vector 14 lands on NMI, 15 on RESET
        mnem_base = MN_IRQ_BASE + MNEM_W'(i_irq_num);
      end
      FMT_SIG_OP: begin
        if (sig_valid) begin
          mnem_base = MN_SIG_BASE + MNEM_W'(i_opcode.sig_op.opc);
        end else begin
          mnem_base = MN_INVALID;
        end
      end
      FMT_JUMP: begin
        mnem_base = MN_JUMP_BASE + MNEM_W'(i_opcode.jump.cond);
      end
      default: begin
        // Two-operand opc runs from 4 (MOV) to 15 (AND)
        mnem_base = MN_TWO_BASE + MNEM_W'(i_opcode.two_op.opc) - MNEM_W'(4);
      end
    endcase
  end

  // Emulated NOP and SBREAK encodings win over the table
  always_comb begin
    if (i_opcode == OP_NOP) begin
      o_mnem = MN_NOP;
    end else if (i_opcode == OP_SBREAK) begin
      o_mnem = MN_SBREAK;
    end else begin
      o_mnem = mnem_base;
    end
  end

  ////////////////////////////////////////
  // Byte flag and registers
  ////////////////////////////////////////

  // Bit 6 is B/W in both operand formats
  always_comb begin
    case (fmt)
      FMT_SIG_OP, FMT_TWO_OP: o_byte = i_opcode.two_op.bw;
      default:                o_byte = 1'b0;
    endcase
  end

  // Source register
  // single-operand uses its one register field
  always_comb begin
    case (fmt)
      FMT_SIG_OP: o_src_reg = i_opcode.sig_op.reg_num;
      FMT_TWO_OP: o_src_reg = i_opcode.two_op.src;
      default:    o_src_reg = '0;
    endcase
  end

  // Destination only exists for two-operand words
  always_comb begin
    if (fmt == FMT_TWO_OP) begin
      o_dst_reg = i_opcode.two_op.dst;
    end else begin
      o_dst_reg = '0;
    end
  end

endmodule

// File: logic/omsp_trace_capture.sv
// Trace capture stage buffering the decoded instruction and counting instructions and cycles
module omsp_trace_capture import omsp_trace_pkg::*; (
  input  logic              mclk,
  input  logic              puc_rst,
  input  logic              i_decode,
  input  logic [DATA_W-1:0] i_ir,
  input  logic [DATA_W-1:0] i_pc,
  input  logic              i_irq_detect,
  input  logic [IRQ_W-1:0]  i_irq_num,
  output op_word_u          o_opcode,
  output logic              o_irq,
  output logic [IRQ_W-1:0]  o_irq_num,
  output logic [DATA_W-1:0] o_inst_pc,
  output logic [CNT_W-1:0]  o_inst_number,
  output logic [CNT_W-1:0]  o_inst_cycle
);

  ////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////

  // Reset state reads as the RESET vector
  // irq set, vector 15, empty opcode
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_opcode  <= '0;
      o_irq     <= 1'b1;
      o_irq_num <= 4'hF;
      o_inst_pc <= '0;
    end else if (i_decode) begin
      o_opcode  <= i_ir;
      o_irq     <= i_irq_detect;
      // Latched with the strobe, not followed live
      o_irq_num <= i_irq_num;
      o_inst_pc <= i_pc;
    end
  end

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  // Instructions since reset
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_inst_number <= '0;
    end else if (i_decode) begin
      o_inst_number <= o_inst_number + 1'b1;
    end
  end

  // Cycles inside the current instruction
  // Restarts at 0 on each strobe
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_inst_cycle <= '0;
    end else if (i_decode) begin
      o_inst_cycle <= '0;
    end else begin
      o_inst_cycle <= o_inst_cycle + 1'b1;
    end
  end

endmodule

// File: logic/omsp_trace_pkg.sv
// Instruction trace package with field widths, trace codes and the opcode word views
package omsp_trace_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////

  // Instruction word and program counter
  localparam int unsigned DATA_W = 16;
  // Instruction and cycle counters
  localparam int unsigned CNT_W  = 32;
  // Register number
  localparam int unsigned REG_W  = 4;
  // Interrupt vector number
  localparam int unsigned IRQ_W  = 4;
  // Trace field codes
  localparam int unsigned FMT_W  = 2;
  localparam int unsigned MNEM_W = 6;
  localparam int unsigned AM_W   = 4;

  ////////////////////////////////////////
  // Instruction format codes
  ////////////////////////////////////////

  localparam logic [FMT_W-1:0] FMT_IRQ    = 2'd0;
  localparam logic [FMT_W-1:0] FMT_SIG_OP = 2'd1;
  localparam logic [FMT_W-1:0] FMT_JUMP   = 2'd2;
  localparam logic [FMT_W-1:0] FMT_TWO_OP = 2'd3;

  ////////////////////////////////////////
  // Mnemonic codes
  ////////////////////////////////////////

  // RRC, SWPB, RRA, SXT, PUSH, CALL, RETI
  localparam logic [MNEM_W-1:0] MN_SIG_BASE  = 6'd0;
  // Single-operand word with a bad prefix or opc 7
  localparam logic [MNEM_W-1:0] MN_INVALID   = 6'd7;
  // JNE, JEQ, JNC, JC, JN, JGE, JL, JMP
  localparam logic [MNEM_W-1:0] MN_JUMP_BASE = 6'd8;
  // MOV through AND, opc 4 maps to this base
  localparam logic [MNEM_W-1:0] MN_TWO_BASE  = 6'd16;
  // Emulated instructions with exact encodings
  localparam logic [MNEM_W-1:0] MN_NOP       = 6'd28;
  localparam logic [MNEM_W-1:0] MN_SBREAK    = 6'd29;
  // IRQ 0..13, then NMI (46) and RESET (47)
  localparam logic [MNEM_W-1:0] MN_IRQ_BASE  = 6'd32;

  ////////////////////////////////////////
  // Addressing mode codes
  ////////////////////////////////////////

  localparam logic [AM_W-1:0] AM_NONE      = 4'd0;
  localparam logic [AM_W-1:0] AM_REG       = 4'd1;
  localparam logic [AM_W-1:0] AM_INDEXED   = 4'd2;
  localparam logic [AM_W-1:0] AM_SYMBOLIC  = 4'd3;
  localparam logic [AM_W-1:0] AM_ABSOLUTE  = 4'd4;
  localparam logic [AM_W-1:0] AM_INDIRECT  = 4'd5;
  localparam logic [AM_W-1:0] AM_AUTOINC   = 4'd6;
  localparam logic [AM_W-1:0] AM_IMMEDIATE = 4'd7;
  localparam logic [AM_W-1:0] AM_CONST     = 4'd8;

  ////////////////////////////////////////
  // Opcode constants
  ////////////////////////////////////////

  // MOV #0, R3
  localparam logic [DATA_W-1:0] OP_NOP    = 16'h4303;
  // Software breakpoint word
  localparam logic [DATA_W-1:0] OP_SBREAK = 16'h4343;

  // Top bits of single-operand and jump words
  localparam logic [5:0] SIG_PREFIX  = 6'b000100;
  localparam logic [2:0] JUMP_PREFIX = 3'b001;

  ////////////////////////////////////////
  // Opcode word views
  ////////////////////////////////////////

  // Same 16 bits, read per instruction format
  typedef union packed {
    // Two-operand: opc[15:12] src[11:8] ad[7] bw[6] as[5:4] dst[3:0]
    struct packed {
      logic [3:0]       opc;
      logic [REG_W-1:0] src;
      logic             ad;
      logic             bw;
      logic [1:0]       as;
      logic [REG_W-1:0] dst;
    } two_op;
    // Single-operand: prefix[15:10] opc[9:7] bw[6] as[5:4] reg[3:0]
    struct packed {
      logic [5:0]       prefix;
      logic [2:0]       opc;
      logic             bw;
      logic [1:0]       as;
      logic [REG_W-1:0] reg_num;
    } sig_op;
    // Jump: prefix[15:13] cond[12:10] offset[9:0]
    struct packed {
      logic [2:0] prefix;
      logic [2:0] cond;
      logic [9:0] offset;
    } jump;
  } op_word_u;

endpackage
